// File: tb.f
+incdir+bench
src/hififo_rx_pkg.sv
src/rx_tlp_control.sv
src/rx_dword_align.sv
src/rx_addr_track.sv
src/rx_read_queue.sv
src/pcie_rx.sv
bench/tb_pcie_rx.sv

// File: run.sh
#!/bin/sh
# build and run the receive path testbench with Verilator
# exit status follows the pass line in the simulator output
verilator --binary --timing --assert -Wno-fatal --top-module tb_pcie_rx -f tb.f -o sim_tb \
   && ./obj_dir/sim_tb | tee /dev/stderr | grep -q "All tests passed" \
   && exit 0 || exit 1

// File: bench/tlp_model.svh
/* TLP model that builds 3 dword header packets as dword lists and predicts
   the data words and read records the receive path should give for them */
`ifndef TLP_MODEL_SVH
`define TLP_MODEL_SVH

// wire byte order to host byte order
function automatic dword_t swap_bytes(input dword_t x);
   dword_t y;
   for (int i = 0; i < 4; i++)
      y[8*i +: 8] = x[8*(3-i) +: 8];
   return y;
endfunction

// dword 0 with attributes and traffic class left clear
function automatic dword_t header_dw0(input fmt_type_t ft, input logic [9:0] len);
   return {1'b0, ft, 14'h0, len};
endfunction

// random payload padded to a whole beat
function automatic void add_payload(input int n);
   for (int i = 0; i < n; i++)
      pkt_dw.push_back($urandom());
   if ((pkt_dw.size() % 2) != 0)
      pkt_dw.push_back($urandom());
endfunction

function automatic void build_write(input logic [9:0] len, input dword_t addr);
   pkt_dw.delete();
   pkt_dw.push_back(header_dw0(FT_MWR32, len));
   // random requester id and tag with all byte enables on
   pkt_dw.push_back($urandom() | 32'h0000_00ff);
   pkt_dw.push_back({addr[31:2], 2'b00});
   add_payload(len);
endfunction

function automatic void build_cpld(input logic [9:0] len, input logic [7:0] tag,
                                   input logic [2:0] slot);
   pkt_dw.delete();
   pkt_dw.push_back(header_dw0(FT_CPLD, len));
   // completer id, status ok, byte count with bits 8..6 as buffer slot
   pkt_dw.push_back(($urandom() & 32'hffff_0e3f) | (32'(slot) << 6));
   // requester id, tag, lower address
   pkt_dw.push_back(($urandom() & 32'hffff_007f) | (32'(tag) << 8));
   add_payload(len);
endfunction

function automatic void build_read(input logic [9:0] len, input logic [15:0] rid,
                                   input logic [7:0] tag, input dword_t addr);
   pkt_dw.delete();
   pkt_dw.push_back(header_dw0(FT_MRD32, len));
   pkt_dw.push_back({rid, tag, 8'h0f});
   pkt_dw.push_back({addr[31:2], 2'b00});
   // no payload and one pad dword
   add_payload(0);
endfunction

// any other type with random header fields
function automatic void build_other(input fmt_type_t ft, input logic [9:0] len);
   pkt_dw.delete();
   pkt_dw.push_back(header_dw0(ft, len));
   pkt_dw.push_back($urandom());
   pkt_dw.push_back($urandom());
   add_payload(len);
endfunction

// expected strobes for the packet now in pkt_dw
function automatic void predict_packet();
   fmt_type_t  ft;
   logic [9:0] len;
   int         n_beats;
   logic [5:0] index;
   beat_t      word;
   ft      = pkt_dw[0][30:24];
   len     = pkt_dw[0][9:0];
   n_beats = pkt_dw.size() / 2;
   // loaded on the header beat from byte count bits 8..6
   // stepped on every data beat, first one included
   index = 6'd63 - {pkt_dw[1][8:6], 3'b000};
   for (int b = 2; b < n_beats; b++)
   begin
      // low dword of this beat on top of high dword of the last one
      word  = {swap_bytes(pkt_dw[2*b]), swap_bytes(pkt_dw[2*b-1])};
      index = index + 6'd1;
      if (ft == FT_MWR32)
         exp_wr.push_back({pkt_dw[2][8:3], word});
      else if (ft == FT_CPLD)
         exp_cpl.push_back({pkt_dw[2][15:8], index, word});
   end
   if ((ft == FT_MRD32) && (len == 10'd1))
   begin
      // a stalled consumer lets the queue fill and extra reads are lost
      if (!hold_reads || (rr_held < RR_DEPTH))
         exp_rr.push_back({pkt_dw[1][31:8], pkt_dw[2][9:2]});
      if (hold_reads)
         rr_held++;
   end
endfunction

`endif

// File: bench/tb_pcie_rx.sv
/* testbench for the PCIe receive path: sends writes, completions and reads
   and checks the data words and the queued read requests */
`timescale 1ns/1ps

module tb_pcie_rx;
   import hififo_rx_pkg::*;

   localparam int RR_DEPTH = 16;

   logic        clock;
   logic        i_rst;
   logic        i_tvalid;
   logic        i_tlast;
   beat_t       i_tdata;
   logic        i_rr_ready;
   logic        o_write_valid;
   logic        o_completion_valid;
   logic [5:0]  o_completion_index;
   logic [7:0]  o_completion_tag;
   beat_t       o_data;
   logic [5:0]  o_address;
   logic [23:0] o_rr_rid_tag;
   logic [7:0]  o_rr_addr;
   logic        o_rr_valid;

   // packet being built, one entry per dword
   dword_t      pkt_dw[$];
   // {address, data} and {tag, index, data}
   logic [69:0] exp_wr[$];
   logic [77:0] exp_cpl[$];
   rr_entry_t   exp_rr[$];
   bit          hold_reads;
   int          rr_held;
   string       test_name;
   int          beats_sent;
   int          n_checks;
   int          n_errors;
   int          cycles;

   `include "tlp_model.svh"

   pcie_rx #(.RR_DEPTH(RR_DEPTH)) DUT
   (
      .clock              (clock),
      .i_rst              (i_rst),
      .i_tvalid           (i_tvalid),
      .i_tlast            (i_tlast),
      .i_tdata            (i_tdata),
      .i_rr_ready         (i_rr_ready),
      .o_write_valid      (o_write_valid),
      .o_completion_valid (o_completion_valid),
      .o_completion_index (o_completion_index),
      .o_completion_tag   (o_completion_tag),
      .o_data             (o_data),
      .o_address          (o_address),
      .o_rr_rid_tag       (o_rr_rid_tag),
      .o_rr_addr          (o_rr_addr),
      .o_rr_valid         (o_rr_valid)
   );

   initial
   begin
      clock = 1'b0;
      forever
         #50 clock = ~clock;
   end

   function automatic void check_value(input string what, input logic [63:0] exp,
                                       input logic [63:0] got);
      n_checks++;
      assert (got === exp)
      else
      begin
         n_errors++;
         $display("Fail %s %s: expected %h, actual %h", test_name, what, exp, got);
      end
   endfunction

   // a strobe with an empty expected queue is an error
   function automatic bit expect_pending(input string what, input int n);
      n_checks++;
      assert (n != 0)
      else
      begin
         n_errors++;
         $display("%s: %s seen while nothing was expected", test_name, what);
      end
      return (n != 0);
   endfunction

   function automatic void report_counts();
      $display("Summary: %0d checks, %0d errors", n_checks, n_errors);
   endfunction

   // outputs are registered, sampled at the rising edge
   always @(posedge clock)
   begin
      logic [69:0] wr;
      logic [77:0] cpl;
      rr_entry_t   rr;
      if ((o_write_valid === 1'b1) && expect_pending("write strobe", exp_wr.size()))
      begin
         wr = exp_wr.pop_front();
         check_value("write data", wr[63:0], o_data);
         check_value("write address", 64'(wr[69:64]), 64'(o_address));
      end
      if ((o_completion_valid === 1'b1) &&
          expect_pending("completion strobe", exp_cpl.size()))
      begin
         cpl = exp_cpl.pop_front();
         check_value("completion data", cpl[63:0], o_data);
         check_value("completion index", 64'(cpl[69:64]), 64'(o_completion_index));
         check_value("completion tag", 64'(cpl[77:70]), 64'(o_completion_tag));
      end
      // a pop happens when valid meets ready
      if ((o_rr_valid === 1'b1) && (i_rr_ready === 1'b1) &&
          expect_pending("read request", exp_rr.size()))
      begin
         rr = exp_rr.pop_front();
         check_value("read id and tag", 64'(rr[31:8]), 64'(o_rr_rid_tag));
         check_value("read address", 64'(rr[7:0]), 64'(o_rr_addr));
      end
   end

   // first n beats of pkt_dw, random idle cycles before each
   task automatic send_beats(input int n, input int max_gap);
      int gap;
      for (int b = 0; b < n; b++)
      begin
         gap = $urandom_range(max_gap, 0);
         repeat (gap)
         begin
            // junk on the bus while idle
            @(negedge clock);
            i_tvalid = 1'b0;
            i_tlast  = 1'($urandom_range(1, 0));
            i_tdata  = {$urandom(), $urandom()};
         end
         @(negedge clock);
         i_tvalid = 1'b1;
         i_tlast  = (b == ((pkt_dw.size() / 2) - 1));
         i_tdata  = {pkt_dw[2*b+1], pkt_dw[2*b]};
         beats_sent++;
      end
      @(negedge clock);
      i_tvalid = 1'b0;
      i_tlast  = 1'b0;
   endtask

   task automatic send_packet(input int max_gap);
      predict_packet();
      send_beats(pkt_dw.size() / 2, max_gap);
   endtask

   task automatic wait_idle();
      while ((exp_wr.size() != 0) || (exp_cpl.size() != 0) || (exp_rr.size() != 0))
         @(negedge clock);
      // room for stray strobes to show up
      repeat (4)
         @(negedge clock);
   endtask

   initial
   begin
      void'($urandom(32'h72a5d43b));
      i_rst      = 1'b1;
      i_tvalid   = 1'b0;
      i_tlast    = 1'b0;
      i_tdata    = '0;
      i_rr_ready = 1'b1;
      hold_reads = 1'b0;
      rr_held    = 0;
      beats_sent = 0;
      n_checks   = 0;
      n_errors   = 0;
      test_name  = "reset";
      repeat (2)
         @(negedge clock);
      i_rst = 1'b0;

      test_name = "mem_write";
      for (int i = 0; i < 12; i++)
      begin
         build_write(10'(2 * $urandom_range(8, 1)), $urandom());
         send_packet(0);
      end
      wait_idle();

      test_name = "completion";
      for (int i = 0; i < 12; i++)
      begin
         build_cpld(10'(2 * $urandom_range(8, 1)), 8'($urandom()), 3'($urandom()));
         send_packet(0);
      end
      wait_idle();

      // consumer stalled, two reads beyond capacity
      test_name  = "read_queue";
      i_rr_ready = 1'b0;
      hold_reads = 1'b1;
      rr_held    = 0;
      for (int i = 0; i < RR_DEPTH + 2; i++)
      begin
         build_read(10'd1, 16'($urandom()), 8'(i), $urandom());
         send_packet(1);
      end
      repeat (4)
         @(negedge clock);
      i_rr_ready = 1'b1;
      hold_reads = 1'b0;
      wait_idle();

      // each ignored packet is followed by one that must decode
      test_name = "ignored";
      build_read(10'(2 + $urandom_range(6, 0)), 16'($urandom()), 8'($urandom()), $urandom());
      send_packet(1);
      build_write(10'd4, $urandom());
      send_packet(1);
      // 4 dword header write
      build_other(7'b110_0000, 10'd4);
      send_packet(1);
      build_read(10'd1, 16'($urandom()), 8'($urandom()), $urandom());
      send_packet(1);
      // config read
      build_other(7'b000_0100, 10'd1);
      send_packet(1);
      build_cpld(10'd6, 8'($urandom()), 3'($urandom()));
      send_packet(1);
      wait_idle();

      test_name = "idle_gaps";
      for (int i = 0; i < 16; i++)
      begin
         case ($urandom_range(2, 0))
            0: build_write(10'(2 * $urandom_range(8, 1)), $urandom());
            1: build_cpld(10'(2 * $urandom_range(8, 1)), 8'($urandom()), 3'($urandom()));
            default: build_read(10'd1, 16'($urandom()), 8'($urandom()), $urandom());
         endcase
         send_packet(3);
      end
      wait_idle();

      // header of a write only, then reset
      test_name = "mid_reset";
      build_write(10'd8, $urandom());
      send_beats(2, 1);
      i_rst = 1'b1;
      repeat (2)
         @(negedge clock);
      i_rst = 1'b0;
      build_write(10'(2 * $urandom_range(8, 1)), $urandom());
      send_packet(2);
      build_cpld(10'(2 * $urandom_range(8, 1)), 8'($urandom()), 3'($urandom()));
      send_packet(2);
      wait_idle();

      report_counts();
      if (n_errors == 0)
         $display("All tests passed");
      else
         $display("Some tests failed");
      $finish;
   end

   // budget grows with the beats sent
   initial
   begin
      cycles = 0;
      while (cycles <= ((20 * beats_sent) + 200))
      begin
         @(posedge clock);
         cycles++;
      end
      $display("Timeout: run stopped after %0d cycles with %0d beats sent", cycles,
               beats_sent);
      report_counts();
      $display("Some tests failed");
      $finish;
   end

endmodule

// File: src/pcie_rx.sv
/* PCIe receive path: decodes memory writes, completions and single dword
   reads from the core's stream into data words and a read request queue */
`timescale 1ns/1ps

module pcie_rx
#(
   parameter int RR_DEPTH = 16
)
(
   input  logic                 clock,
   input  logic                 i_rst,
   input  logic                 i_tvalid,
   input  logic                 i_tlast,
   input  hififo_rx_pkg::beat_t i_tdata,
   input  logic                 i_rr_ready,
   output logic                 o_write_valid,
   output logic                 o_completion_valid,
   output logic [5:0]           o_completion_index,
   output logic [7:0]           o_completion_tag,
   output hififo_rx_pkg::beat_t o_data,
   output logic [5:0]           o_address,
   output logic [23:0]          o_rr_rid_tag,
   output logic [7:0]           o_rr_addr,
   output logic                 o_rr_valid
);
   import hififo_rx_pkg::*;

   logic   beat_valid;
   logic   beat_last;
   beat_t  beat;
   dword_t prev_dw;
   logic   shift;
   logic   hdr_capture;
   logic   addr_capture;
   logic   data_step;
   logic   rr_push;

   rx_dword_align u_align
   (
      .clock        (clock),
      .i_rst        (i_rst),
      .i_tvalid     (i_tvalid),
      .i_tlast      (i_tlast),
      .i_tdata      (i_tdata),
      .i_shift      (shift),
      .o_beat_valid (beat_valid),
      .o_beat_last  (beat_last),
      .o_beat       (beat),
      .o_prev_dw    (prev_dw),
      .o_data       (o_data)
   );

   rx_tlp_control u_control
   (
      .clock              (clock),
      .i_rst              (i_rst),
      .i_beat_valid       (beat_valid),
      .i_beat_last        (beat_last),
      .i_beat             (beat),
      .o_shift            (shift),
      .o_hdr_capture      (hdr_capture),
      .o_addr_capture     (addr_capture),
      .o_data_step        (data_step),
      .o_rr_push          (rr_push),
      .o_write_valid      (o_write_valid),
      .o_completion_valid (o_completion_valid)
   );

   rx_addr_track u_addr
   (
      .clock              (clock),
      .i_rst              (i_rst),
      .i_beat             (beat),
      .i_hdr_capture      (hdr_capture),
      .i_addr_capture     (addr_capture),
      .i_data_step        (data_step),
      .o_address          (o_address),
      .o_completion_tag   (o_completion_tag),
      .o_completion_index (o_completion_index)
   );

   // record: requester id and tag from held dword 1, address from dword 2
   rx_read_queue #(.RR_DEPTH(RR_DEPTH)) u_rr_queue
   (
      .clock   (clock),
      .i_rst   (i_rst),
      .i_push  (rr_push),
      .i_entry ({prev_dw[31:8], beat[9:2]}),
      .i_pop   (i_rr_ready),
      .o_entry ({o_rr_rid_tag, o_rr_addr}),
      .o_valid (o_rr_valid)
   );

endmodule

// File: src/rx_read_queue.sv
/* read request queue: first-word-fall-through FIFO of pending single dword
   reads, head held in an output register */
`timescale 1ns/1ps

module rx_read_queue
#(
   parameter int RR_DEPTH = 16
)
(
   input  logic                     clock,
   input  logic                     i_rst,
   input  logic                     i_push,
   input  hififo_rx_pkg::rr_entry_t i_entry,
   input  logic                     i_pop,
   output hififo_rx_pkg::rr_entry_t o_entry,
   output logic                     o_valid
);
   import hififo_rx_pkg::*;

   localparam int AW = $clog2(RR_DEPTH);

   rr_entry_t     mem [RR_DEPTH];
   logic [AW-1:0] wr_ptr;
   logic [AW-1:0] rd_ptr;
   // entries in mem, head register not included
   logic [AW:0]   mem_cnt;
   logic [AW:0]   occupancy;
   logic          push_ok;
   logic          head_load;

   // capacity counts the head register too
   assign occupancy = mem_cnt + (AW + 1)'(o_valid);
   assign push_ok   = i_push && (occupancy != (AW + 1)'(RR_DEPTH));
   // refill head when empty or being consumed
   assign head_load = (!o_valid || i_pop) && (mem_cnt != '0);

   // storage, written one cycle before it can reach the head
   always_ff @(posedge clock)
   begin
      if (push_ok)
         mem[wr_ptr] <= i_entry;
   end

   always_ff @(posedge clock)
   begin
      if (head_load)
         o_entry <= mem[rd_ptr];
   end

   // pointers wrap naturally, depth is a power of two
   always_ff @(posedge clock)
   begin
      if (i_rst)
      begin
         wr_ptr  <= '0;
         rd_ptr  <= '0;
         mem_cnt <= '0;
         o_valid <= 1'b0;
      end
      else
      begin
         if (push_ok)
            wr_ptr <= wr_ptr + 1'b1;
         if (head_load)
            rd_ptr <= rd_ptr + 1'b1;
         mem_cnt <= mem_cnt + (AW + 1)'(push_ok) - (AW + 1)'(head_load);
         // pop of an empty queue falls through here unchanged
         if (head_load)
            o_valid <= 1'b1;
         else if (i_pop)
            o_valid <= 1'b0;
      end
   end

endmodule

// File: src/rx_addr_track.sv
/* receive address tracker: captures the header word address and completion
   tag, and steps the completion buffer index per data beat */
`timescale 1ns/1ps

module rx_addr_track
(
   input  logic                 clock,
   input  logic                 i_rst,
   input  hififo_rx_pkg::beat_t i_beat,
   input  logic                 i_hdr_capture,
   input  logic                 i_addr_capture,
   input  logic                 i_data_step,
   output logic [5:0]           o_address,
   output logic [7:0]           o_completion_tag,
   output logic [5:0]           o_completion_index
);
   import hififo_rx_pkg::*;

   // address bits 15..3 of dword 2, a 64 bit word address
   // for completions the tag lands in the upper bits
   logic [12:0] address_q;

   always_ff @(posedge clock)
   begin
      if (i_rst)
         address_q <= '0;
      else if (i_addr_capture)
         address_q <= i_beat[15:3];
   end

   assign o_address        = address_q[5:0];
   assign o_completion_tag = address_q[12:5];

   // bits 40..38 sit in the byte count of a completion header
   // index starts one below the buffer slot, first data beat bumps it
   always_ff @(posedge clock)
   begin
      if (i_rst)
         o_completion_index <= '0;
      else if (i_hdr_capture)
         o_completion_index <= 6'h3f - {i_beat[40:38], 3'b000};
      else if (i_data_step)
         o_completion_index <= o_completion_index + 6'd1;
   end

endmodule

// File: src/rx_dword_align.sv
/* receive dword aligner that registers the stream beat, holds the previous
   high dword and builds the byte-swapped, realigned output word */
`timescale 1ns/1ps

module rx_dword_align
(
   input  logic                  clock,
   input  logic                  i_rst,
   input  logic                  i_tvalid,
   input  logic                  i_tlast,
   input  hififo_rx_pkg::beat_t  i_tdata,
   input  logic                  i_shift,
   output logic                  o_beat_valid,
   output logic                  o_beat_last,
   output hififo_rx_pkg::beat_t  o_beat,
   output hififo_rx_pkg::dword_t o_prev_dw,
   output hififo_rx_pkg::beat_t  o_data
);
   import hififo_rx_pkg::*;

   // PCIe dwords arrive big endian on the wire
   function automatic dword_t endian_swap(input dword_t x);
      endian_swap = {x[7:0], x[15:8], x[23:16], x[31:24]};
   endfunction

   // registered stream valid
   always_ff @(posedge clock)
   begin
      if (i_rst)
         o_beat_valid <= 1'b0;
      else
         o_beat_valid <= i_tvalid;
   end

   // beat and last follow the bus every cycle
   always_ff @(posedge clock)
   begin
      o_beat_last <= i_tlast;
      o_beat      <= i_tdata;
   end

   // current low dword goes on top of the previous high dword
   always_ff @(posedge clock)
   begin
      if (i_shift)
      begin
         o_data    <= {endian_swap(o_beat[31:0]), endian_swap(o_prev_dw)};
         o_prev_dw <= o_beat[63:32];
      end
   end

endmodule

// File: src/rx_tlp_control.sv
/* receive control: tracks the header phase, decodes the packet type and
   issues the capture, shift, push and output strobes */
`timescale 1ns/1ps

module rx_tlp_control
(
   input  logic                 clock,
   input  logic                 i_rst,
   input  logic                 i_beat_valid,
   input  logic                 i_beat_last,
   input  hififo_rx_pkg::beat_t i_beat,
   output logic                 o_shift,
   output logic                 o_hdr_capture,
   output logic                 o_addr_capture,
   output logic                 o_data_step,
   output logic                 o_rr_push,
   output logic                 o_write_valid,
   output logic                 o_completion_valid
);
   import hififo_rx_pkg::*;

   rx_phase_t phase;
   fmt_type_t fmt_type;
   tlp_len_t  tlp_len;

   // packet type flags, latched on the header beat
   logic is_write;
   logic is_cpld;
   logic is_read_1dw;

   // fields of header dword 0, low half of the first beat
   assign fmt_type = i_beat[30:24];
   assign tlp_len  = i_beat[9:0];

   // phase advance, any beat with tlast ends the packet
   always_ff @(posedge clock)
   begin
      if (i_rst)
         phase <= PH_HDR;
      else if (i_beat_valid)
      begin
         if (i_beat_last)
            phase <= PH_HDR;
         else if (phase == PH_HDR)
            phase <= PH_ADDR;
         else
            phase <= PH_DATA;
      end
   end

   // decode type once per packet
   always_ff @(posedge clock)
   begin
      if (i_rst)
      begin
         is_write    <= 1'b0;
         is_cpld     <= 1'b0;
         is_read_1dw <= 1'b0;
      end
      else if (i_beat_valid && (phase == PH_HDR))
      begin
         is_write    <= (fmt_type == FT_MWR32);
         is_cpld     <= (fmt_type == FT_CPLD);
         // only single dword reads are queued
         is_read_1dw <= (fmt_type == FT_MRD32) && (tlp_len == tlp_len_t'(1));
      end
   end

   // registered so they line up with o_data
   always_ff @(posedge clock)
   begin
      if (i_rst)
      begin
         o_write_valid      <= 1'b0;
         o_completion_valid <= 1'b0;
      end
      else
      begin
         o_write_valid      <= i_beat_valid && (phase == PH_DATA) && is_write;
         o_completion_valid <= i_beat_valid && (phase == PH_DATA) && is_cpld;
      end
   end

   // datapath moves on every valid beat, header included
   assign o_shift        = i_beat_valid;
   assign o_hdr_capture  = i_beat_valid && (phase == PH_HDR);
   assign o_addr_capture = i_beat_valid && (phase == PH_ADDR);
   assign o_data_step    = i_beat_valid && (phase == PH_DATA);
   // request record is complete on the address beat
   assign o_rr_push      = i_beat_valid && (phase == PH_ADDR) && is_read_1dw;

endmodule

// File: src/hififo_rx_pkg.sv
/* hififo receive package: stream and TLP header field types, header phase
   encoding and the format/type codes the receive path recognizes */
package hififo_rx_pkg;

   // one PCIe dword
   typedef logic [31:0] dword_t;

   // one stream beat, also one output data word
   typedef logic [63:0] beat_t;

   // fmt and type bits of header dword 0, bits 30..24
   typedef logic [6:0] fmt_type_t;

   // length field of header dword 0, in dwords
   typedef logic [9:0] tlp_len_t;

   // queued read request
   // requester id (16), tag (8), dword address bits 9..2 (8)
   typedef logic [31:0] rr_entry_t;

   // where the current beat sits inside the packet
   typedef enum logic [1:0]
   {
      // dwords 0 and 1
      PH_HDR  = 2'd0,
      // dwords 2 and 3
      PH_ADDR = 2'd1,
      // everything after the header
      PH_DATA = 2'd2
   } rx_phase_t;

   // 32 bit memory write, 3 dword header with data
   localparam fmt_type_t FT_MWR32 = 7'b100_0000;

   // completion with data
   localparam fmt_type_t FT_CPLD  = 7'b100_1010;

   // 32 bit memory read, 3 dword header, no data
   localparam fmt_type_t FT_MRD32 = 7'b000_0000;

endpackage
